/* common/psgPkg.sv */
`default_nettype none

package psgPkg;

	// ====================
	// data path widths
	// ====================
	localparam int SampleWidth = 8;
	localparam int AddrWidth = 16;
	// phase increment, low FracBits are the fraction
	localparam int FreqWidth = 16;
	localparam int LengthWidth = 12;
	localparam int VolumeWidth = 8;
	localparam int FracBits = 8;
	// integer part covers the largest table
	localparam int PhaseWidth = LengthWidth + FracBits;

	// ====================
	// register interface
	// ====================
	localparam int RegDataWidth = 16;
	localparam int RegFieldWidth = 3;

	localparam logic [RegFieldWidth-1:0] FieldFreq = 3'd0;
	localparam logic [RegFieldWidth-1:0] FieldBase = 3'd1;
	localparam logic [RegFieldWidth-1:0] FieldLength = 3'd2;
	localparam logic [RegFieldWidth-1:0] FieldVolume = 3'd3;
	localparam logic [RegFieldWidth-1:0] FieldControl = 3'd4;

	// bit of the control field that enables the channel
	localparam int ControlEnableBit = 0;

	typedef logic [SampleWidth-1:0] sample_t;
	typedef logic [AddrWidth-1:0] addr_t;
	typedef logic [FreqWidth-1:0] freq_t;
	typedef logic [LengthWidth-1:0] length_t;
	typedef logic [VolumeWidth-1:0] volume_t;

endpackage

`default_nettype wire

/* rtl/psgBusArb.sv */
`timescale 1ns/1ps
`default_nettype none

module psgBusArb #(
	parameter int NumChannels = 8,
	localparam int IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	// bus is free for a new owner
	input wire logic busRelease,
	input wire logic [NumChannels-1:0] req,
	output logic [NumChannels-1:0] sel,
	output logic [IdxWidth-1:0] seln,
	output logic grant
);

	logic [NumChannels-1:0] lowestReq;
	logic [IdxWidth-1:0] lowestIdx;
	logic takeOwner;

	// isolate the lowest set request bit, requester 0 wins
	assign lowestReq = req & (~req + 1'b1);

	always_comb begin
		lowestIdx = '0;
		// scan downward so the lowest requester is the last one kept
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				lowestIdx = IdxWidth'(i);
			end
		end
	end

	assign takeOwner = ce && busRelease && (|req);

	// ====================
	// owner register
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
			grant <= 1'b0;
		end else begin
			grant <= takeOwner;
			// with no requester the last owner stays
			if (takeOwner) begin
				sel <= lowestReq;
				seln <= lowestIdx;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/psgWaveFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetch
	import psgPkg::*;
#(
	parameter int NumChannels = 8,
	localparam int IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic [NumChannels-1:0] chanReq,
	input wire addr_t [NumChannels-1:0] chanAddr,
	output logic busRead,
	output addr_t busAddr,
	input wire logic busAck,
	input wire sample_t busData,
	output logic [NumChannels-1:0] sampleLoad,
	output sample_t sampleData
);

	typedef enum logic [1:0] {
		StIdle,
		StWait,
		StDeliver
	} fetchState_t;

	fetchState_t state;
	logic busRelease;
	logic grant;
	logic [NumChannels-1:0] sel;
	logic [IdxWidth-1:0] seln;

	psgBusArb #(
		.NumChannels(NumChannels)
	) arb (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.busRelease(busRelease),
		.req(chanReq),
		.sel(sel),
		.seln(seln),
		.grant(grant)
	);

	// a pending grant still occupies the bus
	assign busRelease = (state == StIdle) && !grant;

	// read is issued in the grant cycle itself
	assign busRead = grant;
	assign busAddr = chanAddr[seln];

	// ====================
	// read sequencer
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= StIdle;
			sampleLoad <= '0;
		end else begin
			case (state)
				StIdle: begin
					if (grant) begin
						state <= StWait;
					end
				end
				StWait: begin
					if (busAck) begin
						state <= StDeliver;
						sampleLoad <= sel;
					end
				end
				default: begin
					state <= StIdle;
					sampleLoad <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == StWait && busAck) begin
			sampleData <= busData;
		end
	end

endmodule

`default_nettype wire

/* psgChannel/psgChannelRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module psgChannelRegs
	import psgPkg::*;
#(
	parameter int NumChannels = 8,
	localparam int IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic regWrite,
	// channel index above the field code
	input wire logic [IdxWidth+RegFieldWidth-1:0] regAddr,
	input wire logic [RegDataWidth-1:0] regData,
	output freq_t [NumChannels-1:0] chanFreq,
	output addr_t [NumChannels-1:0] chanBase,
	output length_t [NumChannels-1:0] chanLength,
	output volume_t [NumChannels-1:0] chanVolume,
	output logic [NumChannels-1:0] chanEnable
);

	logic [IdxWidth-1:0] chan;
	logic [RegFieldWidth-1:0] field;
	logic chanValid;

	// ====================
	// address decode
	// ====================
	assign chan = regAddr[RegFieldWidth +: IdxWidth];
	assign field = regAddr[RegFieldWidth-1:0];

	// drops writes past the last channel
	assign chanValid = (int'(chan) < NumChannels);

	// ====================
	// field storage
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			chanFreq <= '0;
			chanBase <= '0;
			chanLength <= '0;
			chanVolume <= '0;
			chanEnable <= '0;
		end else if (regWrite && chanValid) begin
			case (field)
				FieldFreq: begin
					chanFreq[chan] <= freq_t'(regData);
				end
				FieldBase: begin
					chanBase[chan] <= addr_t'(regData);
				end
				FieldLength: begin
					// upper data bits are unused
					chanLength[chan] <= length_t'(regData);
				end
				FieldVolume: begin
					chanVolume[chan] <= volume_t'(regData);
				end
				FieldControl: begin
					// only the enable bit is implemented
					chanEnable[chan] <= regData[ControlEnableBit];
				end
				default: begin
					// unknown field code, nothing stored
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* psgChannel/psgChannel.sv */
`timescale 1ns/1ps
`default_nettype none

module psgChannel
	import psgPkg::*;
#(
	parameter int NumChannels = 8
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic sampleTick,
	input wire freq_t [NumChannels-1:0] chanFreq,
	input wire addr_t [NumChannels-1:0] chanBase,
	input wire length_t [NumChannels-1:0] chanLength,
	input wire logic [NumChannels-1:0] chanEnable,
	input wire logic [NumChannels-1:0] sampleLoad,
	input wire sample_t sampleData,
	output logic [NumChannels-1:0] chanReq,
	output addr_t [NumChannels-1:0] chanAddr,
	output sample_t [NumChannels-1:0] chanSample
);

	for (genvar i = 0; i < NumChannels; i++) begin : gChan
		logic [PhaseWidth-1:0] phase;
		logic [PhaseWidth-1:0] phaseNext;
		logic [PhaseWidth:0] phaseSum;
		logic [PhaseWidth:0] lengthScaled;
		logic reqReg;
		sample_t sampleReg;

		// ====================
		// phase step
		// ====================
		// one extra bit so the sum cannot overflow before the wrap check
		assign phaseSum = {1'b0, phase} + (PhaseWidth + 1)'(chanFreq[i]);
		assign lengthScaled = (PhaseWidth + 1)'({chanLength[i], {FracBits{1'b0}}});

		// integer part reached the length, fold back into the table
		assign phaseNext = (phaseSum >= lengthScaled) ?
			PhaseWidth'(phaseSum - lengthScaled) : PhaseWidth'(phaseSum);

		always_ff @(posedge clk) begin
			if (rst || !chanEnable[i]) begin
				// disabled channel restarts at index 0 with silence
				phase <= '0;
				reqReg <= 1'b0;
				sampleReg <= '0;
			end else begin
				if (sampleTick) begin
					phase <= phaseNext;
				end
				if (sampleLoad[i]) begin
					sampleReg <= sampleData;
				end
				// a fresh tick keeps the request up even on a load
				if (sampleTick) begin
					reqReg <= 1'b1;
				end else if (sampleLoad[i]) begin
					reqReg <= 1'b0;
				end
			end
		end

		// word address of the current table entry
		assign chanAddr[i] = chanBase[i] + AddrWidth'(phase[PhaseWidth-1:FracBits]);
		assign chanReq[i] = reqReg;
		assign chanSample[i] = sampleReg;
	end

endmodule

`default_nettype wire

/* rtl/psgMixer.sv */
`timescale 1ns/1ps
`default_nettype none

module psgMixer
	import psgPkg::*;
#(
	parameter int NumChannels = 8,
	localparam int IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1,
	localparam int MixWidth = SampleWidth + VolumeWidth + IdxWidth
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic sampleTick,
	input wire sample_t [NumChannels-1:0] chanSample,
	input wire volume_t [NumChannels-1:0] chanVolume,
	output logic signed [MixWidth-1:0] mixOut,
	output logic mixValid
);

	logic signed [MixWidth-1:0] mixSum;

	// signed sample times unsigned volume, summed over channels
	always_comb begin
		logic signed [SampleWidth+VolumeWidth:0] product;
		mixSum = '0;
		for (int i = 0; i < NumChannels; i++) begin
			product = $signed(chanSample[i]) * $signed({1'b0, chanVolume[i]});
			mixSum = mixSum + product;
		end
	end

	// ====================
	// output register
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			mixOut <= '0;
			mixValid <= 1'b0;
		end else begin
			mixValid <= sampleTick;
			if (sampleTick) begin
				mixOut <= mixSum;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/psgWaveSystem.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveSystem
	import psgPkg::*;
#(
	parameter int NumChannels = 8,
	localparam int IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1,
	localparam int MixWidth = SampleWidth + VolumeWidth + IdxWidth
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic sampleTick,
	input wire logic regWrite,
	input wire logic [IdxWidth+RegFieldWidth-1:0] regAddr,
	input wire logic [RegDataWidth-1:0] regData,
	output logic busRead,
	output addr_t busAddr,
	input wire logic busAck,
	input wire sample_t busData,
	output logic signed [MixWidth-1:0] mixOut,
	output logic mixValid
);

	// channel configuration
	freq_t [NumChannels-1:0] chanFreq;
	addr_t [NumChannels-1:0] chanBase;
	length_t [NumChannels-1:0] chanLength;
	volume_t [NumChannels-1:0] chanVolume;
	logic [NumChannels-1:0] chanEnable;

	// fetch traffic
	logic [NumChannels-1:0] chanReq;
	addr_t [NumChannels-1:0] chanAddr;
	sample_t [NumChannels-1:0] chanSample;
	logic [NumChannels-1:0] sampleLoad;
	sample_t sampleData;

	psgChannelRegs #(
		.NumChannels(NumChannels)
	) psgChannelRegs_inst (
		.clk(clk),
		.rst(rst),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regData(regData),
		.chanFreq(chanFreq),
		.chanBase(chanBase),
		.chanLength(chanLength),
		.chanVolume(chanVolume),
		.chanEnable(chanEnable)
	);

	psgChannel #(
		.NumChannels(NumChannels)
	) psgChannel_inst (
		.clk(clk),
		.rst(rst),
		.sampleTick(sampleTick),
		.chanFreq(chanFreq),
		.chanBase(chanBase),
		.chanLength(chanLength),
		.chanEnable(chanEnable),
		.sampleLoad(sampleLoad),
		.sampleData(sampleData),
		.chanReq(chanReq),
		.chanAddr(chanAddr),
		.chanSample(chanSample)
	);

	psgWaveFetch #(
		.NumChannels(NumChannels)
	) psgWaveFetch_inst (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.chanReq(chanReq),
		.chanAddr(chanAddr),
		.busRead(busRead),
		.busAddr(busAddr),
		.busAck(busAck),
		.busData(busData),
		.sampleLoad(sampleLoad),
		.sampleData(sampleData)
	);

	psgMixer #(
		.NumChannels(NumChannels)
	) psgMixer_inst (
		.clk(clk),
		.rst(rst),
		.sampleTick(sampleTick),
		.chanSample(chanSample),
		.chanVolume(chanVolume),
		.mixOut(mixOut),
		.mixValid(mixValid)
	);

endmodule

`default_nettype wire

/* verification/psgWaveFetch_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetch_sva #(
	parameter int NumChannels = 8,
	localparam int IdxWidth = (NumChannels > 1) ? $clog2(NumChannels) : 1
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic ce,
	input wire logic busRead,
	input wire logic busAck,
	input wire logic [NumChannels-1:0] sel,
	input wire logic [NumChannels-1:0] sampleLoad,
	input wire logic [IdxWidth-1:0] seln
);

	// high from the read strobe until the memory answers
	logic readOpen;

	always_ff @(posedge clk) begin
		if (rst) begin
			readOpen <= 1'b0;
		end else if (busRead) begin
			readOpen <= 1'b1;
		end else if (busAck) begin
			readOpen <= 1'b0;
		end
	end

	// ====================
	// arbitration and fetch
	// ====================
	// one-hot owner must agree with the owner index
	selOneHot: assert property (@(posedge clk) disable iff (rst)
		(sel == '0) || (sel == (NumChannels'(1) << seln)))
		else $error("sel is neither zero nor the one-hot code of seln");

	singleRead: assert property (@(posedge clk) disable iff (rst) busRead |-> !readOpen)
		else $error("busRead issued while a read is outstanding");

	loadToOwner: assert property (@(posedge clk) disable iff (rst)
		(|sampleLoad) |-> (sampleLoad == sel))
		else $error("sampleLoad does not match the bus owner");

	// owner is frozen while the clock enable is low
	ownerHeld: assert property (@(posedge clk) disable iff (rst)
		!ce |=> ($stable(sel) && $stable(seln)))
		else $error("owner changed while ce was low");

endmodule

bind psgWaveFetch psgWaveFetch_sva #(
	.NumChannels(NumChannels)
) psgWaveFetch_sva_inst (
	.clk(clk),
	.rst(rst),
	.ce(ce),
	.busRead(busRead),
	.busAck(busAck),
	.sel(sel),
	.sampleLoad(sampleLoad),
	.seln(seln)
);

`default_nettype wire

/* verification/psgWaveSystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveSystem_tb
	import psgPkg::*;
();

	localparam int NumChannels = 8;
	localparam int TimeoutCycles = 20000;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic ce = 1'b1;
	logic sampleTick = 1'b0;
	logic regWrite = 1'b0;
	logic [5:0] regAddr = '0;
	logic [RegDataWidth-1:0] regData = '0;
	logic busRead;
	addr_t busAddr;
	logic busAck = 1'b0;
	sample_t busData = '0;
	logic signed [18:0] mixOut;
	logic mixValid;

	sample_t sampleMem [0:65535];
	logic [15:0] stimLfsr = 16'd74;
	logic [15:0] delayLfsr = 16'd74;
	int cycleCount = 0;
	int errorCount = 0;

	// memory model bookkeeping
	int readCount = 0;
	int ackCount = 0;
	int pendDelay = 0;
	addr_t pendAddr;
	addr_t addrLog [0:255];

	// reference copy of the registers and channel state
	int refFreq [NumChannels];
	int refBase [NumChannels];
	int refLength [NumChannels];
	int refVolume [NumChannels];
	int refPhase [NumChannels];
	int refSample [NumChannels];
	bit refEnable [NumChannels];
	int checkedReads = 0;

	psgWaveSystem #(
		.NumChannels(NumChannels)
	) psgWaveSystem_inst (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.sampleTick(sampleTick),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regData(regData),
		.busRead(busRead),
		.busAddr(busAddr),
		.busAck(busAck),
		.busData(busData),
		.mixOut(mixOut),
		.mixValid(mixValid)
	);

	always #5 clk = ~clk;

	task automatic reportFailure();
		errorCount++;
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
			reportFailure();
		end
	end

	task automatic checkValue(string name, int got, int expected);
		assert (got == expected) else begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
			reportFailure();
		end
	endtask

	// galois form with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrStep(inout logic [15:0] state);
		logic outBit;
		outBit = state[0];
		state = state >> 1;
		if (outBit) begin
			state = state ^ 16'hB400;
		end
		return outBit;
	endfunction

	function automatic int randBits(inout logic [15:0] state, input int width);
		int value;
		value = 0;
		for (int i = 0; i < width; i++) begin
			value = (value << 1) | lfsrStep(state);
		end
		return value;
	endfunction

	// ====================
	// sample memory
	// ====================
	always @(negedge clk) begin
		busAck = 1'b0;
		if (rst) begin
			pendDelay = 0;
		end else if (busRead) begin
			addrLog[readCount] <= busAddr;
			readCount <= readCount + 1;
			pendAddr = busAddr;
			pendDelay = 1 + randBits(delayLfsr, 2);
		end else if (pendDelay > 0) begin
			pendDelay = pendDelay - 1;
			if (pendDelay == 0) begin
				busAck = 1'b1;
				busData = sampleMem[pendAddr];
				ackCount <= ackCount + 1;
			end
		end
	end

	// ====================
	// stimulus tasks
	// ====================
	task automatic writeReg(int chan, logic [RegFieldWidth-1:0] field, int data);
		regWrite = 1'b1;
		regAddr = {3'(chan), field};
		regData = 16'(data);
		@(negedge clk);
		regWrite = 1'b0;
		case (field)
			FieldFreq: refFreq[chan] = data & 'hFFFF;
			FieldBase: refBase[chan] = data & 'hFFFF;
			FieldLength: refLength[chan] = data & 'hFFF;
			FieldVolume: refVolume[chan] = data & 'hFF;
			FieldControl: begin
				refEnable[chan] = (data & 1) != 0;
				// disabling restarts at index 0 with silence
				if (!refEnable[chan]) begin
					refPhase[chan] = 0;
					refSample[chan] = 0;
				end
			end
			default: ;
		endcase
	endtask

	task automatic setupChannel(int chan, int freq, int base, int length, int volume);
		writeReg(chan, FieldFreq, freq);
		writeReg(chan, FieldBase, base);
		writeReg(chan, FieldLength, length);
		writeReg(chan, FieldVolume, volume);
		writeReg(chan, FieldControl, 1);
	endtask

	function automatic int expectedMix();
		int sum;
		sum = 0;
		for (int c = 0; c < NumChannels; c++) begin
			sum += refSample[c] * refVolume[c];
		end
		return sum;
	endfunction

	task automatic issueTick();
		int expected;
		expected = expectedMix();
		sampleTick = 1'b1;
		@(negedge clk);
		sampleTick = 1'b0;
		checkValue("mixValid", mixValid, 1);
		checkValue("mixOut", mixOut, expected);
		for (int c = 0; c < NumChannels; c++) begin
			if (refEnable[c]) begin
				refPhase[c] += refFreq[c];
				// fold back once when the index reaches the table length
				if (refPhase[c] >= refLength[c] * 256) begin
					refPhase[c] -= refLength[c] * 256;
				end
			end
		end
		// mixValid is a single-cycle pulse
		@(negedge clk);
		checkValue("mixValid", mixValid, 0);
	endtask

	task automatic collectReads();
		int pending;
		int addr;
		pending = 0;
		for (int c = 0; c < NumChannels; c++) begin
			if (refEnable[c]) begin
				pending++;
			end
		end
		while (ackCount < checkedReads + pending) begin
			@(negedge clk);
		end
		// delivery then the store into the channel
		repeat (3) @(negedge clk);
		// reads come out in ascending channel order
		for (int c = 0; c < NumChannels; c++) begin
			if (refEnable[c]) begin
				addr = (refBase[c] + (refPhase[c] >> FracBits)) & 'hFFFF;
				checkValue("busAddr", addrLog[checkedReads], addr);
				refSample[c] = $signed(sampleMem[addr]);
				checkedReads++;
			end
		end
		checkValue("read count", readCount, checkedReads);
	endtask

	// ====================
	// tests
	// ====================
	task automatic testResetState();
		repeat (5) begin
			@(negedge clk);
			checkValue("busRead", busRead, 0);
			checkValue("mixValid", mixValid, 0);
			checkValue("mixOut", mixOut, 0);
		end
		repeat (4) begin
			issueTick();
			repeat (4) @(negedge clk);
		end
		checkValue("read count", readCount, 0);
	endtask

	task automatic testSingleChannel();
		// 1.5 entries per tick through a five entry table
		setupChannel(2, 'h0180, 'h1234, 5, 37);
		repeat (12) begin
			issueTick();
			collectReads();
		end
	endtask

	task automatic testPriority();
		setupChannel(6, 'h0100, 'h6000, 9, 200);
		setupChannel(0, 'h0240, 'h0100, 16, 11);
		setupChannel(5, 'h0080, 'hFFFC, 7, 90);
		repeat (2) begin
			issueTick();
			collectReads();
		end
	endtask

	task automatic testClockEnable();
		ce = 1'b0;
		issueTick();
		repeat (20) @(negedge clk);
		checkValue("read count while ce low", readCount, checkedReads);
		ce = 1'b1;
		collectReads();
		issueTick();
		collectReads();
	endtask

	task automatic testFullMix();
		int freq;
		int base;
		int length;
		int volume;
		for (int c = 0; c < NumChannels; c++) begin
			freq = randBits(stimLfsr, 9);
			base = randBits(stimLfsr, 16);
			length = 4 + randBits(stimLfsr, 6);
			volume = randBits(stimLfsr, 8);
			setupChannel(c, freq, base, length, volume);
		end
		repeat (3) begin
			issueTick();
			collectReads();
		end
		writeReg(5, FieldControl, 0);
		// held sample clears on the edge after the enable drops
		@(negedge clk);
		repeat (3) begin
			issueTick();
			collectReads();
		end
		writeReg(5, FieldControl, 1);
		repeat (4) begin
			issueTick();
			collectReads();
		end
	endtask

	initial begin
		for (int a = 0; a < 65536; a++) begin
			sampleMem[a] = sample_t'(randBits(stimLfsr, SampleWidth));
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		testResetState();
		testSingleChannel();
		testPriority();
		testClockEnable();
		testFullMix();
		if (errorCount == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			reportFailure();
		end
	end

endmodule

`default_nettype wire

/* list.f */
common/psgPkg.sv
rtl/psgBusArb.sv
rtl/psgWaveFetch.sv
psgChannel/psgChannelRegs.sv
psgChannel/psgChannel.sv
rtl/psgMixer.sv
rtl/psgWaveSystem.sv
verification/psgWaveFetch_sva.sv
verification/psgWaveSystem_tb.sv
